// ==== logic/cfg_sequencer.sv ====
`timescale 1ns/10ps

module cfg_sequencer #(
    parameter int unsigned INIT_LEN = rx_regmap_pkg::INIT_LEN,
    parameter int unsigned STEP_W   = 6
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  i2c_cmd_pkg::xfer_evt_t      evt,
    input  rx_regmap_pkg::status_word_t status,
    output i2c_cmd_pkg::cfg_phase_e     phase,
    output logic [STEP_W-1:0]           step,
    output logic                        issue,
    output logic                        init_over
);
    import rx_regmap_pkg::*;
    import i2c_cmd_pkg::*;

    localparam logic [STEP_W-1:0] INIT_LAST    = STEP_W'(INIT_LEN - 1);
    localparam logic [STEP_W-1:0] POLL_LAST    = STEP_W'(STATUS_BYTES - 1);
    localparam logic [STEP_W-1:0] SETTING_LAST = STEP_W'(SETTING_LEN - 1);

    logic [1:0] prev_lock;
    logic       prev_vld;
    logic [1:0] cur_lock;
    logic       lock_hit;

    // ==================================================
    // lock rule
    // ==================================================

    assign cur_lock = status[LOCK_LSB +: 2];

    // needs a valid word from the poll before
    assign lock_hit = prev_vld && (prev_lock == LOCK_PREV) && (cur_lock == LOCK_CUR);

    // ==================================================
    // phase FSM and step counter
    // ==================================================

    always_ff @(posedge clk) begin
        if (!rstn) begin
            phase     <= IDLE;
            step      <= '0;
            issue     <= 1'b0;
            init_over <= 1'b0;
            prev_lock <= '0;
            prev_vld  <= 1'b0;
        end else begin
            // next command goes out after every completion
            issue <= evt.done;

            case (phase)
                IDLE: begin
                    phase <= LINK;
                    step  <= '0;
                    issue <= 1'b1;
                end

                LINK: begin
                    if (evt.done) begin
                        if (step == '0) begin
                            step <= STEP_W'(1);
                        end else if (evt.rd_data == LINK_MAGIC) begin
                            phase <= INIT;
                            step  <= '0;
                        end else begin
                            // wrong readback means write again
                            step <= '0;
                        end
                    end
                end

                INIT: begin
                    if (evt.done) begin
                        if (step == INIT_LAST) begin
                            phase <= POLL;
                            step  <= '0;
                        end else begin
                            step <= step + 1'b1;
                        end
                    end
                end

                POLL: begin
                    if (evt.done) begin
                        if (step == POLL_LAST) begin
                            step <= '0;
                            if (lock_hit) begin
                                phase    <= SETTING;
                                prev_vld <= 1'b0;
                            end else begin
                                prev_lock <= cur_lock;
                                prev_vld  <= 1'b1;
                            end
                        end else begin
                            step <= step + 1'b1;
                        end
                    end
                end

                SETTING: begin
                    if (evt.done) begin
                        if (step == SETTING_LAST) begin
                            phase     <= POLL;
                            step      <= '0;
                            init_over <= 1'b1;
                        end else begin
                            step <= step + 1'b1;
                        end
                    end
                end

                default: begin
                    phase <= IDLE;
                    step  <= '0;
                end
            endcase
        end
    end

endmodule

// ==== logic/i2c_cmd_issue.sv ====
`timescale 1ns/10ps

module i2c_cmd_issue #(
    parameter int unsigned INIT_LEN = rx_regmap_pkg::INIT_LEN,
    parameter int unsigned STEP_W   = 6
) (
    input  logic                       clk,
    input  logic                       rstn,
    input  i2c_cmd_pkg::cfg_phase_e    phase,
    input  logic [STEP_W-1:0]          step,
    input  logic                       issue,
    output logic [STEP_W-1:0]          tbl_idx,
    input  rx_regmap_pkg::init_entry_t entry,
    output i2c_cmd_pkg::i2c_cmd_t      cmd,
    output logic                       iic_trig
);
    import rx_regmap_pkg::*;
    import i2c_cmd_pkg::*;

    i2c_cmd_t    cmd_nxt;
    init_entry_t set_entry;
    logic        init_hit;

    // writes after the input clock locks
    function automatic init_entry_t setting_entry(input logic [2:0] idx);
        case (idx)
            3'd0:    setting_entry = {16'h1010, 8'h01};
            3'd1:    setting_entry = {16'h1024, 8'h00};
            3'd2:    setting_entry = {16'h0200, 8'h00};
            3'd3:    setting_entry = {16'h1024, 8'h70};
            3'd4:    setting_entry = {16'h0200, 8'h07};
            3'd5:    setting_entry = {16'h0215, 8'h01};
            3'd6:    setting_entry = {16'h0215, 8'h00};
            default: setting_entry = {16'h0215, 8'h00};
        endcase
    endfunction

    assign tbl_idx   = step;
    assign init_hit  = (int'(step) < INIT_LEN);
    assign set_entry = setting_entry(step[2:0]);

    // ==================================================
    // command select
    // ==================================================

    always_comb begin
        cmd_nxt = '{wr: 1'b1, addr: '0, data: '0};
        case (phase)
            LINK: begin
                if (step == '0) begin
                    cmd_nxt = '{wr: 1'b1, addr: LINK_ADDR, data: LINK_MAGIC};
                end else begin
                    cmd_nxt = '{wr: 1'b0, addr: LINK_ADDR, data: '0};
                end
            end
            INIT: begin
                if (init_hit) begin
                    cmd_nxt.addr = entry.addr;
                    cmd_nxt.data = entry.data;
                end
            end
            POLL: begin
                cmd_nxt.wr   = 1'b0;
                cmd_nxt.addr = STATUS_BASE + reg_addr_t'(step);
            end
            SETTING: begin
                cmd_nxt.addr = set_entry.addr;
                cmd_nxt.data = set_entry.data;
            end
            default: begin
            end
        endcase
    end

    // command stays on the bus until the next trigger
    always_ff @(posedge clk) begin
        if (!rstn) begin
            iic_trig <= 1'b0;
            cmd      <= '{wr: 1'b1, addr: '0, data: '0};
        end else begin
            iic_trig <= issue;
            if (issue) begin
                cmd <= cmd_nxt;
            end
        end
    end

endmodule

// ==== logic/i2c_cmd_pkg.sv ====
package i2c_cmd_pkg;

    // ==================================================
    // controller phases
    // ==================================================

    typedef enum logic [2:0] {
        IDLE,
        LINK,
        INIT,
        POLL,
        SETTING
    } cfg_phase_e;

    // ==================================================
    // I2C master side
    // ==================================================

    // command handed to the byte-wide master with the trigger
    typedef struct packed {
        logic                     wr;
        rx_regmap_pkg::reg_addr_t addr;
        rx_regmap_pkg::reg_data_t data;
    } i2c_cmd_t;

    // one transfer finished
    typedef struct packed {
        logic                     done;
        rx_regmap_pkg::reg_data_t rd_data;
    } xfer_evt_t;

endpackage

// ==== logic/i2c_event_monitor.sv ====
`timescale 1ns/10ps

module i2c_event_monitor #(
    parameter int unsigned STEP_W = 6
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        busy,
    input  logic                        byte_over,
    input  rx_regmap_pkg::reg_data_t    data_out,
    input  i2c_cmd_pkg::cfg_phase_e     phase,
    input  logic [STEP_W-1:0]           step,
    output i2c_cmd_pkg::xfer_evt_t      evt,
    output rx_regmap_pkg::status_word_t status
);
    import rx_regmap_pkg::*;
    import i2c_cmd_pkg::*;

    localparam int unsigned LANE_W = $clog2(STATUS_BYTES);

    logic              busy_d;
    reg_data_t         rd_byte;
    logic [LANE_W-1:0] lane;

    // ==================================================
    // transfer completion
    // ==================================================

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy_d <= 1'b0;
        end else begin
            busy_d <= busy;
        end
    end

    // last byte returned by the master
    always_ff @(posedge clk) begin
        if (byte_over) begin
            rd_byte <= data_out;
        end
    end

    assign evt = '{done: busy_d & ~busy, rd_data: rd_byte};

    // ==================================================
    // status word assembly
    // ==================================================

    // poll step picks the byte lane
    assign lane = step[LANE_W-1:0];

    always_ff @(posedge clk) begin
        if (byte_over && phase == POLL) begin
            status[8*lane +: 8] <= data_out;
        end
    end

endmodule

// ==== logic/rx_cfg_ctl.sv ====
`timescale 1ns/10ps

module rx_cfg_ctl #(
    parameter int unsigned INIT_LEN = rx_regmap_pkg::INIT_LEN,
    parameter int unsigned STEP_W   = 6
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     busy,
    input  logic                     byte_over,
    input  rx_regmap_pkg::reg_data_t data_out,
    output logic                     iic_trig,
    output logic                     w_r,
    output logic                     init_over,
    output rx_regmap_pkg::reg_addr_t addr,
    output rx_regmap_pkg::reg_data_t data_in
);
    import rx_regmap_pkg::*;
    import i2c_cmd_pkg::*;

    xfer_evt_t         evt;
    status_word_t      status;
    cfg_phase_e        phase;
    logic [STEP_W-1:0] step;
    logic              issue;
    logic [STEP_W-1:0] tbl_idx;
    init_entry_t       entry;
    i2c_cmd_t          cmd;

    i2c_event_monitor #(.STEP_W(STEP_W)) u_monitor (
        .clk      (clk),
        .rstn     (rstn),
        .busy     (busy),
        .byte_over(byte_over),
        .data_out (data_out),
        .phase    (phase),
        .step     (step),
        .evt      (evt),
        .status   (status)
    );

    cfg_sequencer #(.INIT_LEN(INIT_LEN), .STEP_W(STEP_W)) u_sequencer (
        .clk      (clk),
        .rstn     (rstn),
        .evt      (evt),
        .status   (status),
        .phase    (phase),
        .step     (step),
        .issue    (issue),
        .init_over(init_over)
    );

    i2c_cmd_issue #(.INIT_LEN(INIT_LEN), .STEP_W(STEP_W)) u_issue (
        .clk     (clk),
        .rstn    (rstn),
        .phase   (phase),
        .step    (step),
        .issue   (issue),
        .tbl_idx (tbl_idx),
        .entry   (entry),
        .cmd     (cmd),
        .iic_trig(iic_trig)
    );

    rx_init_table #(.STEP_W(STEP_W)) u_table (
        .tbl_idx(tbl_idx),
        .entry  (entry)
    );

    // command fields out to the I2C master
    assign w_r     = cmd.wr;
    assign addr    = cmd.addr;
    assign data_in = cmd.data;

endmodule

// ==== logic/rx_init_table.sv ====
`timescale 1ns/10ps

module rx_init_table #(
    parameter int unsigned STEP_W = 6
) (
    input  logic [STEP_W-1:0]          tbl_idx,
    output rx_regmap_pkg::init_entry_t entry
);
    import rx_regmap_pkg::*;

    localparam init_entry_t ROM [INIT_LEN] = '{
        // ==================================================
        // base setup
        // ==================================================
        {16'h0204, 8'h02},
        {16'h0205, 8'h40},
        {16'h0004, 8'h01},
        {16'h0009, 8'h26},
        {16'h102E, 8'h01},
        {16'h1025, 8'hB0},
        {16'h102D, 8'h83},
        {16'h1000, 8'h20},
        {16'h100F, 8'h04},
        {16'h0003, 8'hC3},
        {16'h103B, 8'h02},
        {16'h00E1, 8'h00},
        {16'h00A8, 8'h08},
        {16'h000A, 8'h00},
        {16'h0016, 8'h02},
        {16'h00E2, 8'h01},
        {16'h00C2, 8'h14},
        // rx phy and equalizer
        {16'h102D, 8'hC7},
        {16'h1005, 8'h04},
        {16'h1003, 8'h14},
        {16'h1004, 8'h01},
        {16'h1000, 8'h60},
        {16'h1020, 8'h13},
        {16'h1021, 8'h04},
        {16'h1022, 8'h04},
        {16'h1023, 8'h0C},
        {16'h102B, 8'h33},
        {16'h102C, 8'h33},
        {16'h00F0, 8'h10},
        {16'h000C, 8'h80},
        // edid access closed again
        {16'h000C, 8'h00},
        {16'h000A, 8'h04},
        // output port enables
        {16'h2000, 8'h0F},
        {16'h2001, 8'h00},
        {16'h2002, 8'h00},
        {16'h2003, 8'h01}
    };

    always_comb begin
        if (int'(tbl_idx) < INIT_LEN) begin
            entry = ROM[tbl_idx];
        end else begin
            entry = '0;
        end
    end

endmodule

// ==== logic/rx_regmap_pkg.sv ====
package rx_regmap_pkg;

    // ==================================================
    // receiver register space
    // ==================================================

    typedef logic [15:0] reg_addr_t;
    typedef logic [7:0]  reg_data_t;

    // one init write with the address in the upper 16 bits
    typedef struct packed {
        reg_addr_t addr;
        reg_data_t data;
    } init_entry_t;

    // four input-clock status bytes with the lowest address in bits 7:0
    typedef logic [31:0] status_word_t;

    // number of entries in the init ROM
    localparam int unsigned INIT_LEN = 36;

    // ==================================================
    // link check
    // ==================================================

    localparam reg_addr_t LINK_ADDR  = 16'h0003;
    localparam reg_data_t LINK_MAGIC = 8'h5A;

    // ==================================================
    // status polling and lock
    // ==================================================

    localparam reg_addr_t   STATUS_BASE  = 16'h209C;
    localparam int unsigned STATUS_BYTES = 4;

    // writes after a lock
    localparam int unsigned SETTING_LEN = 7;

    // clock detect field sits at bits 17:16
    localparam int unsigned LOCK_LSB  = 16;
    localparam logic [1:0]  LOCK_PREV = 2'b00;
    localparam logic [1:0]  LOCK_CUR  = 2'b10;

endpackage

// ==== sim/tb_i2c_responder.sv ====
`timescale 1ns/10ps

module tb_i2c_responder (
    input  logic                        clk,
    input  logic                        iic_trig,
    input  logic                        w_r,
    input  rx_regmap_pkg::reg_addr_t    addr,
    input  rx_regmap_pkg::reg_data_t    data_in,
    input  rx_regmap_pkg::status_word_t status_word,
    output logic                        busy,
    output logic                        byte_over,
    output rx_regmap_pkg::reg_data_t    data_out,
    output int                          word_idx
);
    import rx_regmap_pkg::*;

    reg_data_t regs [0:65535];
    reg_data_t rd_val;
    int        busy_left;
    int        link_reads;

    initial begin
        busy       = 1'b0;
        byte_over  = 1'b0;
        data_out   = '0;
        rd_val     = '0;
        word_idx   = 0;
        busy_left  = 0;
        link_reads = 0;
    end

    // ==================================================
    // one transfer per trigger
    // ==================================================

    always @(posedge clk) begin
        byte_over <= 1'b0;
        if (iic_trig) begin
            busy      <= 1'b1;
            busy_left <= $urandom_range(20, 3);
            if (w_r) begin
                regs[addr] <= data_in;
            end else if (addr == LINK_ADDR) begin
                // link not up for the first two readbacks
                rd_val     <= (link_reads < 2) ? 8'h00 : regs[addr];
                link_reads <= link_reads + 1;
            end else if (addr >= STATUS_BASE && addr < STATUS_BASE + STATUS_BYTES) begin
                rd_val <= status_word[8*(addr - STATUS_BASE) +: 8];
                if (addr == STATUS_BASE + STATUS_BYTES - 1) begin
                    word_idx <= word_idx + 1;
                end
            end else begin
                rd_val <= regs[addr];
            end
        end else if (busy) begin
            // byte done one cycle before busy drops
            if (busy_left == 2) begin
                byte_over <= 1'b1;
                data_out  <= rd_val;
            end
            if (busy_left == 1) begin
                busy <= 1'b0;
            end
            busy_left <= busy_left - 1;
        end
    end

endmodule

// ==== sim/tb_rx_cfg_ctl.sv ====
`timescale 1ns/10ps

module tb_rx_cfg_ctl;
    import rx_regmap_pkg::*;
    import i2c_cmd_pkg::*;

    // write/read pairs until the responder answers the link check
    localparam int LINK_TRIES   = 3;
    localparam int N_WORDS      = 8;
    // third poll shows that 10 after 10 does not lock
    localparam int POLLS_AFTER  = 3;
    localparam int WATCHDOG_CYC = (INIT_LEN + 60) * 25;

    // ==================================================
    // reference register writes as address and value
    // ==================================================

    localparam logic [23:0] INIT_REF [INIT_LEN] = '{
        24'h020402, 24'h020540, 24'h000401, 24'h000926, 24'h102E01, 24'h1025B0,
        24'h102D83, 24'h100020, 24'h100F04, 24'h0003C3, 24'h103B02, 24'h00E100,
        24'h00A808, 24'h000A00, 24'h001602, 24'h00E201, 24'h00C214, 24'h102DC7,
        24'h100504, 24'h100314, 24'h100401, 24'h100060, 24'h102013, 24'h102104,
        24'h102204, 24'h10230C, 24'h102B33, 24'h102C33, 24'h00F010, 24'h000C80,
        24'h000C00, 24'h000A04, 24'h20000F, 24'h200100, 24'h200200, 24'h200301
    };

    localparam logic [23:0] SET_REF [SETTING_LEN] = '{
        24'h101001, 24'h102400, 24'h020000, 24'h102470, 24'h020007, 24'h021501, 24'h021500
    };

    logic         clk = 1'b0;
    logic         rstn;
    logic         busy;
    logic         byte_over;
    reg_data_t    data_out;
    logic         iic_trig;
    logic         w_r;
    logic         init_over;
    reg_addr_t    addr;
    reg_data_t    data_in;
    status_word_t status_word;
    int           word_idx;

    status_word_t words [N_WORDS];
    i2c_cmd_t     exp_q [$];
    i2c_cmd_t     exp_cmd;
    int           errors = 0;
    int           cyc = 0;
    int           mark = 0;
    int           set_end = 0;
    int           over_cyc = 0;
    int           n_trig = 0;
    int           seed;
    logic         rstn_q = 1'b0;
    logic         busy_q = 1'b0;

    rx_cfg_ctl #(.INIT_LEN(INIT_LEN), .STEP_W(6)) DUT (.*);

    tb_i2c_responder u_responder (.*);

    always #5 clk = ~clk;

    assign status_word = words[(word_idx < N_WORDS) ? word_idx : N_WORDS - 1];

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %0t %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    task automatic expect_cmd(input logic wr, input reg_addr_t a, input reg_data_t d);
        exp_q.push_back('{wr: wr, addr: a, data: d});
    endtask

    task automatic expect_poll();
        for (int b = 0; b < STATUS_BYTES; b++) begin
            expect_cmd(1'b0, STATUS_BASE + reg_addr_t'(b), '0);
        end
    endtask

    // ==================================================
    // expected command sequence
    // ==================================================

    task automatic build_expected();
        logic [1:0] prev;
        logic       prev_ok;
        logic       lock;
        int         n;
        prev    = '0;
        prev_ok = 1'b0;
        lock    = 1'b0;
        n       = 0;
        for (int i = 0; i < LINK_TRIES; i++) begin
            expect_cmd(1'b1, LINK_ADDR, LINK_MAGIC);
            expect_cmd(1'b0, LINK_ADDR, '0);
        end
        for (int i = 0; i < INIT_LEN; i++) begin
            expect_cmd(1'b1, INIT_REF[i][23:8], INIT_REF[i][7:0]);
        end
        // lock needs 00 then 10 in two polls in a row
        while (!lock && n < N_WORDS) begin
            expect_poll();
            lock    = prev_ok && prev == LOCK_PREV && words[n][LOCK_LSB +: 2] == LOCK_CUR;
            prev    = words[n][LOCK_LSB +: 2];
            prev_ok = 1'b1;
            n++;
        end
        for (int i = 0; i < SETTING_LEN; i++) begin
            expect_cmd(1'b1, SET_REF[i][23:8], SET_REF[i][7:0]);
        end
        set_end = exp_q.size();
        for (int i = 0; i < POLLS_AFTER; i++) begin
            expect_poll();
        end
    endtask

    initial begin
        rstn = 1'b0;
        seed = $urandom(32'h243e);
        for (int i = 0; i < N_WORDS; i++) begin
            words[i] = $urandom();
            words[i][LOCK_LSB +: 2] = (i == 1 || i == 2) ? 2'b00 : 2'b10;
        end
        build_expected();
        repeat (5) @(posedge clk);
        check("iic_trig", 1'b0, iic_trig);
        check("w_r", 1'b1, w_r);
        check("init_over", 1'b0, init_over);
        rstn <= 1'b1;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        $display("run complete, errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // ==================================================
    // per-cycle checks
    // ==================================================

    always @(posedge clk) begin
        cyc++;
        if (rstn && !rstn_q) begin
            mark = cyc;
        end
        if (busy_q && !busy) begin
            mark = cyc;
            if (n_trig == set_end && over_cyc == 0) begin
                over_cyc = cyc + 1;
            end
        end
        if (rstn) begin
            check("init_over", over_cyc != 0 && cyc >= over_cyc, init_over);
        end
        if (rstn && iic_trig) begin
            check("trig delay", 2, cyc - mark);
            if (exp_q.size() == 0) begin
                errors++;
                $display("trigger at %0t with no command left to expect", $time);
            end else begin
                exp_cmd = exp_q.pop_front();
                check("w_r", exp_cmd.wr, w_r);
                check("addr", exp_cmd.addr, addr);
                if (exp_cmd.wr) begin
                    check("data_in", exp_cmd.data, data_in);
                end
                n_trig++;
            end
        end
        rstn_q = rstn;
        busy_q = busy;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("timeout with %0d commands still outstanding", exp_q.size());
        $display("run aborted, errors: %0d", errors + 1);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
logic/rx_regmap_pkg.sv
logic/i2c_cmd_pkg.sv
logic/rx_init_table.sv
logic/i2c_event_monitor.sv
logic/cfg_sequencer.sv
logic/i2c_cmd_issue.sv
logic/rx_cfg_ctl.sv
sim/tb_i2c_responder.sv
sim/tb_rx_cfg_ctl.sv
